// File: source/issue_pkg.sv
// shared definitions for the long-instruction issue subsystem
// widths, execution class and opcode enums, decoded instruction word
`default_nettype none

package issue_pkg;

    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int INST_W     = 32;  // rv32 instruction word

    // execution lane class
    typedef enum logic [1:0] {
        CLS_ALU = 2'd0,
        CLS_CSR = 2'd1,
        CLS_MUL = 2'd2
    } exu_class_e;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP        = 7'b0110011,
        LUI       = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        SYSTEM    = 7'b1110011
    } opcode_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rd_we;   // writes rd, never set for x0
        logic                  rs1_re;
        logic                  rs2_re;
        exu_class_e            cls;
    } dec_inst_t;

endpackage

`default_nettype wire

// File: source/issue_ifs.sv
// internal buses of the issue subsystem
// issue_if carries decoded instructions into hazard check and lanes,
// commit_if carries the two retire ports back to the hazard table
`timescale 1ns/100ps
`default_nettype none

interface issue_if #(
    parameter int TABLE_DEPTH = 8
);
    localparam int ID_W = $clog2(TABLE_DEPTH);

    logic                  valid;    // decoded instruction waiting
    issue_pkg::dec_inst_t  inst;
    logic                  stall;    // hold, conflict or table full
    logic [ID_W-1:0]       id;       // commit id handed out on accept
    logic                  fwd_op1;  // rs1 taken from latest alu result
    logic                  fwd_op2;

    modport src  (output valid, output inst, input stall);
    modport sink (input valid, input inst,
                  output stall, output id, output fwd_op1, output fwd_op2);
    modport mon  (input valid, input inst, input stall, input id);
endinterface

interface commit_if #(
    parameter int TABLE_DEPTH = 8
);
    localparam int ID_W = $clog2(TABLE_DEPTH);

    logic            valid1;  // alu/csr lane, one cycle pulse
    logic [ID_W-1:0] id1;
    logic            valid2;  // mul lane
    logic [ID_W-1:0] id2;

    modport src  (output valid1, output id1, output valid2, output id2);
    modport sink (input valid1, input id1, input valid2, input id2);
endinterface

`default_nettype wire

// File: source/decode_stage.sv
// decode stage
// four-phase req/ack capture of instruction words, then classification
// into alu, csr or mul with register read/write flags
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         inst_req_i,  // four-phase request
    input  wire logic [issue_pkg::INST_W-1:0] inst_i,      // stable while req high
    output logic                              inst_ack_o,
    issue_if.src                              iss
);

    typedef enum logic [1:0] {
        IDLE,      // waiting for a request
        ISSUE,     // word held, valid towards hazard unit
        ACK_WAIT   // ack high until req drops
    } state_e;

    state_e                      state_q;
    logic [issue_pkg::INST_W-1:0] inst_q;   // captured word
    issue_pkg::opcode_e          opcode;
    issue_pkg::dec_inst_t        dec;
    logic                        wr;        // opcode writes rd
    logic                        accept;

    assign accept = (state_q == ISSUE) && !iss.stall;

    // handshake fsm
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:     if (inst_req_i) state_q <= ISSUE;
                ISSUE:    if (accept) state_q <= ACK_WAIT;      // stall holds us here
                ACK_WAIT: if (!inst_req_i) state_q <= IDLE;     // phase 3 seen
                default:  state_q <= IDLE;
            endcase
        end
    end

    // word register, loaded once per request
    always_ff @(posedge clk) begin
        if (state_q == IDLE && inst_req_i) inst_q <= inst_i;
    end

    // classification of the held word
    always_comb begin
        opcode     = issue_pkg::opcode_e'(inst_q[6:0]);
        dec        = '0;
        dec.rd     = inst_q[11:7];
        dec.rs1    = inst_q[19:15];
        dec.rs2    = inst_q[24:20];
        dec.cls    = issue_pkg::CLS_ALU;  // unknown opcodes touch no registers
        wr         = 1'b0;
        case (opcode)
            issue_pkg::OP: begin
                dec.rs1_re = 1'b1;
                dec.rs2_re = 1'b1;
                wr         = 1'b1;
                if (inst_q[31:25] == 7'd1) dec.cls = issue_pkg::CLS_MUL;  // m extension
            end
            issue_pkg::OP_IMM: begin
                dec.rs1_re = 1'b1;
                wr         = 1'b1;
            end
            issue_pkg::LUI: begin
                wr = 1'b1;                        // immediate only
            end
            issue_pkg::SYSTEM: begin
                dec.cls    = issue_pkg::CLS_CSR;
                dec.rs1_re = !inst_q[14];         // funct3[2] set means uimm form
                wr         = 1'b1;
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        dec.rd_we = wr && (dec.rd != '0);        // x0 writes are dropped
    end

    assign iss.valid  = (state_q == ISSUE);
    assign iss.inst   = dec;
    assign inst_ack_o = (state_q == ACK_WAIT);   // rises the cycle after accept

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
// hazard unit
// in-flight table of issued instructions, raw/waw checks against it,
// lowest-free commit id allocation and alu forwarding flags
`timescale 1ns/100ps
`default_nettype none

module hazard_unit #(
    parameter int TABLE_DEPTH = 8
) (
    input  wire logic clk,
    input  wire logic rst_n,
    issue_if.sink     iss,
    commit_if.sink    cmt,
    output logic      lock_o   // any instruction still in flight
);

    localparam int ID_W = $clog2(TABLE_DEPTH);

    // table, destination and class per entry
    logic [TABLE_DEPTH-1:0]           ent_vld_q;
    logic [issue_pkg::REG_ADDR_W-1:0] ent_rd_q  [TABLE_DEPTH];  // x0 for non-writers
    issue_pkg::exu_class_e            ent_cls_q [TABLE_DEPTH];

    // latest alu writer still in flight
    logic                             fwd_vld_q;
    logic [ID_W-1:0]                  fwd_id_q;

    logic [TABLE_DEPTH-1:0]           live;      // valid and not retiring now
    logic [TABLE_DEPTH-1:0]           raw_vec;
    logic [TABLE_DEPTH-1:0]           waw_vec;
    logic [TABLE_DEPTH-1:0]           fwd_mask;
    logic [ID_W-1:0]                  free_id;
    logic                             full;
    logic                             conflict;
    logic                             fwd_reader;
    logic                             fwd_hit;
    logic                             accept;
    logic [issue_pkg::REG_ADDR_W-1:0] fwd_rd;

    // per-entry conflict vectors
    always_comb begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            live[i] = ent_vld_q[i]
                   && !(cmt.valid1 && cmt.id1 == ID_W'(i))   // retiring entries no longer block
                   && !(cmt.valid2 && cmt.id2 == ID_W'(i))
                   && (ent_rd_q[i] != '0);                   // x0 never conflicts
            raw_vec[i] = live[i]
                      && ((iss.inst.rs1_re && iss.inst.rs1 == ent_rd_q[i])
                       || (iss.inst.rs2_re && iss.inst.rs2 == ent_rd_q[i]));
            waw_vec[i] = live[i] && iss.inst.rd_we
                      && (iss.inst.rd == ent_rd_q[i])
                      && (iss.inst.cls != ent_cls_q[i]);     // same lane keeps order itself
        end
    end

    // lowest free slot, scanned from the top down
    always_comb begin
        free_id = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld_q[i]) free_id = ID_W'(i);
        end
    end

    assign full       = &ent_vld_q;
    assign fwd_reader = (iss.inst.cls == issue_pkg::CLS_ALU)
                     || (iss.inst.cls == issue_pkg::CLS_CSR);
    assign fwd_mask   = (fwd_vld_q && fwd_reader) ? (TABLE_DEPTH'(1) << fwd_id_q) : '0;
    assign conflict   = (|(raw_vec & ~fwd_mask)) || (|waw_vec);

    assign iss.stall  = full || (iss.valid && conflict);
    assign iss.id     = free_id;
    assign accept     = iss.valid && !iss.stall;

    // forwarding, only the masked alu entry may be bypassed
    assign fwd_rd      = ent_rd_q[fwd_id_q];
    assign fwd_hit     = iss.valid && fwd_reader && fwd_vld_q && live[fwd_id_q];
    assign iss.fwd_op1 = fwd_hit && iss.inst.rs1_re && (iss.inst.rs1 == fwd_rd);
    assign iss.fwd_op2 = fwd_hit && iss.inst.rs2_re && (iss.inst.rs2 == fwd_rd);

    // valid bits, retire first and allocate after
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld_q <= '0;
        end else begin
            if (cmt.valid1) ent_vld_q[cmt.id1] <= 1'b0;
            if (cmt.valid2) ent_vld_q[cmt.id2] <= 1'b0;
            if (accept)     ent_vld_q[free_id] <= 1'b1;   // free_id not retiring
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (accept) begin
            ent_rd_q[free_id]  <= iss.inst.rd_we ? iss.inst.rd : '0;
            ent_cls_q[free_id] <= iss.inst.cls;
        end
    end

    // track the newest alu writer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_vld_q <= 1'b0;
            fwd_id_q  <= '0;
        end else begin
            if (cmt.valid1 && cmt.id1 == fwd_id_q) fwd_vld_q <= 1'b0;  // alu result retired
            if (accept && iss.inst.cls == issue_pkg::CLS_ALU && iss.inst.rd_we) begin
                fwd_vld_q <= 1'b1;   // newer writer wins
                fwd_id_q  <= free_id;
            end
        end
    end

    assign lock_o = |ent_vld_q;

endmodule

`default_nettype wire

// File: source/exec_lanes.sv
// execution lanes
// one-cycle alu/csr lane on commit port 1 and a pipelined mul lane
// of MUL_STAGES steps on commit port 2
`timescale 1ns/100ps
`default_nettype none

module exec_lanes #(
    parameter int TABLE_DEPTH = 8,
    parameter int MUL_STAGES  = 3
) (
    input  wire logic clk,
    input  wire logic rst_n,
    issue_if.mon      iss,
    commit_if.src     cmt
);

    localparam int ID_W = $clog2(TABLE_DEPTH);

    logic                  accept;
    logic                  is_mul;

    // alu/csr lane, single register
    logic                  alu_vld_q;
    logic [ID_W-1:0]       alu_id_q;

    // mul lane, valid-tagged shift pipe
    logic [MUL_STAGES-1:0] mul_vld_q;
    logic [ID_W-1:0]       mul_id_q [MUL_STAGES];

    assign accept = iss.valid && !iss.stall;   // same accept rule as hazard unit
    assign is_mul = (iss.inst.cls == issue_pkg::CLS_MUL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_vld_q <= 1'b0;
        end else begin
            alu_vld_q <= accept && !is_mul;    // pulse, commit next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_mul) alu_id_q <= iss.id;
    end

    // mul valids advance every cycle, one issue per cycle allowed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_vld_q <= '0;
        end else begin
            mul_vld_q[0] <= accept && is_mul;
            for (int k = 1; k < MUL_STAGES; k++) begin
                mul_vld_q[k] <= mul_vld_q[k-1];
            end
        end
    end

    // ids ride along without reset
    always_ff @(posedge clk) begin
        mul_id_q[0] <= iss.id;
        for (int k = 1; k < MUL_STAGES; k++) begin
            mul_id_q[k] <= mul_id_q[k-1];
        end
    end

    assign cmt.valid1 = alu_vld_q;
    assign cmt.id1    = alu_id_q;
    assign cmt.valid2 = mul_vld_q[MUL_STAGES-1];  // MUL_STAGES cycles after accept
    assign cmt.id2    = mul_id_q[MUL_STAGES-1];

endmodule

`default_nettype wire

// File: source/issue_top.sv
// issue subsystem top level
// decode, hazard unit and execution lanes joined by the issue and
// commit buses, everything brought out on plain ports
`timescale 1ns/100ps
`default_nettype none

module issue_top #(
    parameter int TABLE_DEPTH = 8,
    parameter int MUL_STAGES  = 3
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             inst_req_i,
    input  wire logic [issue_pkg::INST_W-1:0]     inst_i,
    output logic                                  inst_ack_o,
    output logic                                  stall_o,
    output logic                                  lock_o,
    output logic                                  issue_valid_o,   // accept event
    output logic [$clog2(TABLE_DEPTH)-1:0]        issue_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0]      issue_rd_o,
    output issue_pkg::exu_class_e                 issue_cls_o,
    output logic                                  fwd_op1_o,
    output logic                                  fwd_op2_o,
    output logic                                  commit_valid1_o,
    output logic [$clog2(TABLE_DEPTH)-1:0]        commit_id1_o,
    output logic                                  commit_valid2_o,
    output logic [$clog2(TABLE_DEPTH)-1:0]        commit_id2_o
);

    issue_if  #(.TABLE_DEPTH(TABLE_DEPTH)) iss_bus ();
    commit_if #(.TABLE_DEPTH(TABLE_DEPTH)) cmt_bus ();

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .iss        (iss_bus.src)
    );

    hazard_unit #(.TABLE_DEPTH(TABLE_DEPTH)) u_hazard (
        .clk    (clk),
        .rst_n  (rst_n),
        .iss    (iss_bus.sink),
        .cmt    (cmt_bus.sink),
        .lock_o (lock_o)
    );

    exec_lanes #(.TABLE_DEPTH(TABLE_DEPTH), .MUL_STAGES(MUL_STAGES)) u_lanes (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (iss_bus.mon),
        .cmt   (cmt_bus.src)
    );

    assign stall_o         = iss_bus.stall;
    assign issue_valid_o   = iss_bus.valid && !iss_bus.stall;
    assign issue_id_o      = iss_bus.id;
    assign issue_rd_o      = iss_bus.inst.rd;
    assign issue_cls_o     = iss_bus.inst.cls;
    assign fwd_op1_o       = iss_bus.fwd_op1;
    assign fwd_op2_o       = iss_bus.fwd_op2;
    assign commit_valid1_o = cmt_bus.valid1;
    assign commit_id1_o    = cmt_bus.id1;
    assign commit_valid2_o = cmt_bus.valid2;
    assign commit_id2_o    = cmt_bus.id2;

endmodule

`default_nettype wire

// File: verification/issue_checker.sv
// issue checker
// watches the issue_top ports, keeps its own in-flight table and
// predicts ids, hazards, forwarding flags and commit timing
`timescale 1ns/100ps
`default_nettype none

module issue_checker #(
    parameter int TABLE_DEPTH = 8,
    parameter int MUL_STAGES  = 3
) (
    input wire logic                           clk,
    input wire logic                           rst_n,
    input wire logic [31:0]                    inst_i,      // word on the request lines
    input wire logic [1:0]                     exp_cls_i,   // from the pattern file
    input wire logic [4:0]                     exp_rd_i,
    input wire logic                           inst_ack_i,
    input wire logic                           stall_i,
    input wire logic                           lock_i,
    input wire logic                           issue_valid_i,
    input wire logic [$clog2(TABLE_DEPTH)-1:0] issue_id_i,
    input wire logic [4:0]                     issue_rd_i,
    input wire logic [1:0]                     issue_cls_i,
    input wire logic                           fwd_op1_i,
    input wire logic                           fwd_op2_i,
    input wire logic                           commit_valid1_i,
    input wire logic [$clog2(TABLE_DEPTH)-1:0] commit_id1_i,
    input wire logic                           commit_valid2_i,
    input wire logic [$clog2(TABLE_DEPTH)-1:0] commit_id2_i
);

    localparam int ID_W = $clog2(TABLE_DEPTH);

    logic            ref_vld [TABLE_DEPTH];  // reference in-flight table
    logic [4:0]      ref_rd  [TABLE_DEPTH];
    logic            ref_wr  [TABLE_DEPTH];
    logic [1:0]      ref_cls [TABLE_DEPTH];
    int              ref_cyc [TABLE_DEPTH];  // accept cycle
    logic            fwd_vld;                // newest alu writer still pending
    logic [ID_W-1:0] fwd_id;
    int              cyc;
    int              errors  = 0;
    int              accepts = 0;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_text(input string what);
        $display("error at t=%0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_cycle();
        int         cnt;
        int         lowest;
        bit         live [TABLE_DEPTH];
        bit         rs1_re;
        bit         rs2_re;
        bit         rd_we;
        bit         fwd_live;
        bit         raw;
        bit         waw;
        logic [4:0] rs1;
        logic [4:0] rs2;
        cnt    = 0;
        lowest = -1;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            live[i] = ref_vld[i] && ref_wr[i]
                   && !(commit_valid1_i && commit_id1_i == ID_W'(i))  // retiring now
                   && !(commit_valid2_i && commit_id2_i == ID_W'(i));
            if (ref_vld[i]) cnt++;
            else if (lowest < 0) lowest = i;
        end
        if (lock_i !== (cnt != 0)) report_value("lock_o", lock_i, cnt != 0);
        if (cnt == TABLE_DEPTH && stall_i !== 1'b1) report_value("stall_o", stall_i, 1);
        // every entry due this cycle must show up on its own port
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (ref_vld[i] && ref_cls[i] == issue_pkg::CLS_MUL && ref_cyc[i] + MUL_STAGES == cyc
                && !(commit_valid2_i && commit_id2_i == ID_W'(i)))
                report_text($sformatf("mul id %0d not committed on port 2", i));
            if (ref_vld[i] && ref_cls[i] != issue_pkg::CLS_MUL && ref_cyc[i] + 1 == cyc
                && !(commit_valid1_i && commit_id1_i == ID_W'(i)))
                report_text($sformatf("alu/csr id %0d not committed on port 1", i));
        end
        if (commit_valid1_i && (!ref_vld[commit_id1_i] || ref_cyc[commit_id1_i] + 1 != cyc
            || ref_cls[commit_id1_i] == issue_pkg::CLS_MUL))
            report_text($sformatf("unexpected commit of id %0d on port 1", commit_id1_i));
        if (commit_valid2_i && (!ref_vld[commit_id2_i]
            || ref_cyc[commit_id2_i] + MUL_STAGES != cyc
            || ref_cls[commit_id2_i] != issue_pkg::CLS_MUL))
            report_text($sformatf("unexpected commit of id %0d on port 2", commit_id2_i));
        if (issue_valid_i) begin
            accepts++;
            rs1    = inst_i[19:15];
            rs2    = inst_i[24:20];
            rs1_re = inst_i[6:0] inside {7'h33, 7'h13} || (inst_i[6:0] == 7'h73 && !inst_i[14]);
            rs2_re = inst_i[6:0] == 7'h33;                   // only register-register ops
            rd_we  = inst_i[6:0] inside {7'h33, 7'h13, 7'h37, 7'h73} && inst_i[11:7] != 5'd0;
            if (issue_cls_i !== exp_cls_i) report_value("issue_cls_o", issue_cls_i, exp_cls_i);
            if (issue_rd_i !== exp_rd_i) report_value("issue_rd_o", issue_rd_i, exp_rd_i);
            if (lowest < 0) report_text("instruction accepted with a full table");
            else if (issue_id_i !== ID_W'(lowest)) report_value("issue_id_o", issue_id_i, lowest);
            fwd_live = fwd_vld && exp_cls_i != issue_pkg::CLS_MUL && live[fwd_id];
            raw      = 1'b0;
            waw      = 1'b0;
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                if (live[i] && !(fwd_live && fwd_id == ID_W'(i))
                    && ((rs1_re && rs1 == ref_rd[i]) || (rs2_re && rs2 == ref_rd[i])))
                    raw = 1'b1;
                if (live[i] && rd_we && inst_i[11:7] == ref_rd[i] && ref_cls[i] != exp_cls_i)
                    waw = 1'b1;                              // other lane, same rd
            end
            if (raw) report_text("instruction accepted over a RAW hazard");
            if (waw) report_text("instruction accepted over a WAW hazard");
            if (fwd_op1_i !== (fwd_live && rs1_re && rs1 == ref_rd[fwd_id]))
                report_value("fwd_op1_o", fwd_op1_i, fwd_live && rs1_re && rs1 == ref_rd[fwd_id]);
            if (fwd_op2_i !== (fwd_live && rs2_re && rs2 == ref_rd[fwd_id]))
                report_value("fwd_op2_o", fwd_op2_i, fwd_live && rs2_re && rs2 == ref_rd[fwd_id]);
        end
        // retire, then allocate
        if (commit_valid1_i) ref_vld[commit_id1_i] = 1'b0;
        if (commit_valid2_i) ref_vld[commit_id2_i] = 1'b0;
        if (commit_valid1_i && commit_id1_i == fwd_id) fwd_vld = 1'b0;
        if (issue_valid_i && lowest >= 0) begin
            ref_vld[lowest] = 1'b1;
            ref_rd[lowest]  = inst_i[11:7];
            ref_wr[lowest]  = rd_we;
            ref_cls[lowest] = exp_cls_i;
            ref_cyc[lowest] = cyc;
            if (exp_cls_i == issue_pkg::CLS_ALU && rd_we) begin
                fwd_vld = 1'b1;
                fwd_id  = ID_W'(lowest);
            end
        end
    endtask

    // sampled mid-cycle, inputs and outputs are settled by then
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TABLE_DEPTH; i++) ref_vld[i] = 1'b0;
            fwd_vld = 1'b0;
            fwd_id  = '0;
            cyc     = 0;
            if (inst_ack_i || stall_i || lock_i || issue_valid_i || commit_valid1_i
                || commit_valid2_i)
                report_text("control output active during reset");
        end else begin
            check_cycle();
            cyc++;
        end
    end

endmodule

`default_nettype wire

// File: verification/issue_assert.sv
// protocol assertions for issue_top
// four-phase ordering, ack quiet without request, stall, commit ports
`timescale 1ns/100ps
`default_nettype none

module issue_assert #(
    parameter int TABLE_DEPTH = 8
) (
    input wire logic                           clk,
    input wire logic                           rst_n,
    input wire logic                           inst_req_i,
    input wire logic                           inst_ack_i,
    input wire logic                           stall_i,
    input wire logic                           commit_valid1_i,
    input wire logic [$clog2(TABLE_DEPTH)-1:0] commit_id1_i,
    input wire logic                           commit_valid2_i,
    input wire logic [$clog2(TABLE_DEPTH)-1:0] commit_id2_i
);

    int unsigned fails = 0;   // summed up by the testbench

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_ack_i) |-> $past(inst_req_i))
        else begin fails++; $error("ack rose without a request"); end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(inst_req_i) |-> inst_ack_i)
        else begin fails++; $error("request dropped before ack"); end

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(inst_ack_i) |-> $past(!inst_req_i))
        else begin fails++; $error("ack dropped while request high"); end

    req_restart: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_req_i) |-> !inst_ack_i)
        else begin fails++; $error("new request before ack low"); end

    ack_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !inst_req_i && !inst_ack_i |=> !inst_ack_i)
        else begin fails++; $error("ack raised with no request"); end

    stall_holds_ack: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> !$rose(inst_ack_i))
        else begin fails++; $error("ack rose after a stalled cycle"); end

    commit_ids_differ: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid1_i && commit_valid2_i |-> commit_id1_i != commit_id2_i)
        else begin fails++; $error("same id on both commit ports"); end

endmodule

bind issue_top issue_assert #(.TABLE_DEPTH(TABLE_DEPTH)) u_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .inst_req_i      (inst_req_i),
    .inst_ack_i      (inst_ack_o),
    .stall_i         (stall_o),
    .commit_valid1_i (commit_valid1_o),
    .commit_id1_i    (commit_id1_o),
    .commit_valid2_i (commit_valid2_o),
    .commit_id2_i    (commit_id2_o)
);

`default_nettype wire

// File: verification/tb_issue_top.sv
// testbench for the issue subsystem
// reads instruction patterns, runs the four-phase request port with
// random gaps and leaves the comparing to the checker
`timescale 1ns/100ps
`default_nettype none

module tb_issue_top;

    localparam int TABLE_DEPTH = 2;    // two overlapping muls fill the table
    localparam int MUL_STAGES  = 7;    // longer than the issue spacing, muls overlap
    localparam int ID_W        = $clog2(TABLE_DEPTH);
    localparam int MAX_PAT     = 64;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_req;
    logic [31:0]           inst;
    logic                  inst_ack;
    logic                  stall;
    logic                  lock;
    logic                  issue_valid;
    logic [ID_W-1:0]       issue_id;
    logic [4:0]            issue_rd;
    issue_pkg::exu_class_e issue_cls;
    logic                  fwd_op1;
    logic                  fwd_op2;
    logic                  cvalid1;
    logic [ID_W-1:0]       cid1;
    logic                  cvalid2;
    logic [ID_W-1:0]       cid2;

    logic [31:0]           pat_word [MAX_PAT];
    logic [1:0]            pat_cls  [MAX_PAT];
    logic [4:0]            pat_rd   [MAX_PAT];
    logic [1:0]            exp_cls;            // pattern now on the request lines
    logic [4:0]            exp_rd;
    logic [31:0]           lfsr;
    int                    n_pat;
    int                    limit;
    int                    cycles;
    int                    tb_errors;
    int                    gap;

    issue_top #(.TABLE_DEPTH(TABLE_DEPTH), .MUL_STAGES(MUL_STAGES)) dut (
        .clk(clk), .rst_n(rst_n), .inst_req_i(inst_req), .inst_i(inst),
        .inst_ack_o(inst_ack), .stall_o(stall), .lock_o(lock),
        .issue_valid_o(issue_valid), .issue_id_o(issue_id), .issue_rd_o(issue_rd),
        .issue_cls_o(issue_cls), .fwd_op1_o(fwd_op1), .fwd_op2_o(fwd_op2),
        .commit_valid1_o(cvalid1), .commit_id1_o(cid1),
        .commit_valid2_o(cvalid2), .commit_id2_o(cid2)
    );

    issue_checker #(.TABLE_DEPTH(TABLE_DEPTH), .MUL_STAGES(MUL_STAGES)) chk (
        .clk(clk), .rst_n(rst_n), .inst_i(inst), .exp_cls_i(exp_cls), .exp_rd_i(exp_rd),
        .inst_ack_i(inst_ack), .stall_i(stall), .lock_i(lock),
        .issue_valid_i(issue_valid), .issue_id_i(issue_id), .issue_rd_i(issue_rd),
        .issue_cls_i(issue_cls), .fwd_op1_i(fwd_op1), .fwd_op2_i(fwd_op2),
        .commit_valid1_i(cvalid1), .commit_id1_i(cid1),
        .commit_valid2_i(cvalid2), .commit_id2_i(cid2)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_gap(output int g);
        lfsr = lfsr_next(lfsr);          // one step per bit
        g    = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        g    = g + 2 * int'(lfsr[0]);
    endtask

    task automatic load_patterns();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] w;
        logic [31:0] c;
        logic [31:0] r;
        fd = $fopen("verification/issue_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file could not be opened");
            tb_errors++;
            return;
        end
        while (!$feof(fd) && n_pat < MAX_PAT) begin
            rc = $fgets(line, fd);
            if (rc > 0 && $sscanf(line, "%h %h %h", w, c, r) == 3) begin  // comments fail here
                pat_word[n_pat] = w;
                pat_cls[n_pat]  = c[1:0];
                pat_rd[n_pat]   = r[4:0];
                n_pat++;
            end
        end
        $fclose(fd);
    endtask

    // full four-phase cycle, called 1 ns after an edge
    task automatic send_inst(input int p);
        inst     = pat_word[p];
        exp_cls  = pat_cls[p];
        exp_rd   = pat_rd[p];
        inst_req = 1'b1;
        while (!inst_ack) begin
            @(posedge clk);
            #1;
        end
        inst_req = 1'b0;
        while (inst_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, handshake or drain stuck", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        inst_req  = 1'b0;
        inst      = '0;
        exp_cls   = '0;
        exp_rd    = '0;
        lfsr      = 32'hee54b30e;
        n_pat     = 0;
        limit     = 0;
        cycles    = 0;
        tb_errors = 0;
        load_patterns();
        limit = 40 * n_pat + 100;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int p = 0; p < n_pat; p++) begin
            pick_gap(gap);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_inst(p);
        end
        while (lock || inst_ack) begin   // let the table drain
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        if (n_pat == 0 || chk.accepts != n_pat) begin
            $display("accepted %0d instructions, pattern file holds %0d", chk.accepts, n_pat);
            tb_errors++;
        end
        $display("errors: checker %0d, assertions %0d, testbench %0d",
                 chk.errors, dut.u_assert.fails, tb_errors);
        if (chk.errors == 0 && dut.u_assert.fails == 0 && tb_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/issue_pkg.sv
source/issue_ifs.sv
source/decode_stage.sv
source/hazard_unit.sv
source/exec_lanes.sv
source/issue_top.sv
verification/issue_checker.sv
verification/issue_assert.sv
verification/tb_issue_top.sv

// File: run_sim.sh
#!/bin/sh
# build the issue subsystem testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_issue_top -f compile.f -o sim_issue

./obj_dir/sim_issue +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    exit 1
fi

// File: verification/issue_patterns.txt
// instruction word, class (0 alu, 1 csr, 2 mul), destination register, all hex
// covers overlapping muls, raw and waw stalls, both csr forms and an x0 destination
00500093 0 01
021082B3 2 05
02310333 2 06
006283B3 0 07
34039473 1 08
123454B7 0 09
02948533 2 0a
00100513 0 0a
02A505B3 2 0b
02058633 2 0c
300026F3 1 0d
00C60033 0 00
40208733 0 0e
02D707B3 2 0f
02F78833 2 10
3412D8F3 1 11
